// File: bench/tb_decoder.sv
// Self-checking testbench for the instruction decode stage.
// Random instruction words come from an LFSR, a reference model built from
// the format and fault rules predicts the decode bus, and immediate
// assertions compare each output group on the falling edge, where it is stable.
// Each test prints one summary line, followed by a closing line with the counts.

`timescale 1ns/100ps
`default_nettype none

module tb_decoder;

	localparam int VECS       = 200;
	localparam int N_TESTS    = 6;
	// Each test runs VECS vectors and one final check at one clock each, plus reset and slack
	localparam int TIMEOUT_NS = N_TESTS * (VECS + 1) * 20 + 1000;

	logic clk, rst, en, instr_valid;
	logic [31:0] ip;
	decode_pkg::mode_t om;
	decode_pkg::instr_t instr;
	logic dec_valid, rdz, rs1z, rs2z, has_rs2, has_imm, mem, sync;
	logic is_alu, is_mul, is_div, is_load, is_store, is_branch, is_fence, is_nop;
	decode_pkg::reg_t rd, rs1, rs2;
	decode_pkg::value_t imm;
	logic [31:0] br_target;
	decode_pkg::cause_t cause;

	// Expected decode bus, kept in the groups that get compared
	logic [18:0] exp_regs;    // {rd, rs1, rs2, rdz, rs1z, rs2z, has_rs2}
	logic [64:0] exp_const;   // {imm, has_imm, br_target}
	logic [10:0] exp_class;   // {dec_valid, eight class flags, mem, sync}
	decode_pkg::cause_t exp_cause;

	logic [16:0] lfsr;
	string test_name;
	int errors, test_errors, checks;
	decode_pkg::opcode_t known_ops [10];

	decoder DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog for a run that stops making progress
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Errors found");
		$finish;
	end

	// ======================================================================
	// Stimulus source and reference model
	// ======================================================================

	// Fibonacci LFSR with taps 17 and 14, one step for every bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// Predicts the bus registered for one enabled slot
	task automatic set_expected(input decode_pkg::instr_t w, input logic [31:0] pc,
			input decode_pkg::mode_t m, input logic valid);
		decode_pkg::opcode_t op;
		logic r_fmt, i_fmt, s_fmt, u_fmt, known;
		decode_pkg::reg_t e_rd, e_rs1, e_rs2;
		decode_pkg::value_t e_imm;
		logic [7:0] cls;
		op = w[6:0];
		r_fmt = op inside {decode_pkg::OP_ADD, decode_pkg::OP_MUL, decode_pkg::OP_DIV};
		i_fmt = op inside {decode_pkg::OP_ADDI, decode_pkg::OP_LOAD};
		s_fmt = op inside {decode_pkg::OP_STORE, decode_pkg::OP_BEQ};
		u_fmt = op == decode_pkg::OP_LUI;
		known = r_fmt || i_fmt || s_fmt || u_fmt || op == decode_pkg::OP_NOP ||
			op == decode_pkg::OP_FENCE;
		e_rd  = (r_fmt || i_fmt || u_fmt) ? w[11:7] : 5'd0;
		e_rs1 = (r_fmt || i_fmt || s_fmt) ? w[16:12] : 5'd0;
		// Stores and branches take their second source from the rd position
		e_rs2 = r_fmt ? w[21:17] : (s_fmt ? w[11:7] : 5'd0);
		if (u_fmt)
			e_imm = {w[31:12], 12'h000};
		else if (i_fmt || s_fmt)
			e_imm = {{17{w[31]}}, w[31:17]};
		else
			e_imm = '0;
		cls = {op inside {decode_pkg::OP_ADD, decode_pkg::OP_ADDI, decode_pkg::OP_LUI},
			op == decode_pkg::OP_MUL, op == decode_pkg::OP_DIV, op == decode_pkg::OP_LOAD,
			op == decode_pkg::OP_STORE, op == decode_pkg::OP_BEQ,
			op == decode_pkg::OP_FENCE, op == decode_pkg::OP_NOP};
		if (!valid || !known) begin
			// Reset image, an unknown opcode still counts as a slot with a fault
			exp_regs  = {15'd0, 1'b1, 3'd0};
			exp_const = '0;
			exp_class = {valid, 7'd0, !valid, 2'd0};
			exp_cause = valid ? decode_pkg::FLT_UNIMP : decode_pkg::FLT_NONE;
		end
		else begin
			exp_regs  = {e_rd, e_rs1, e_rs2, e_rd == 5'd0, e_rs1 == 5'd0, e_rs2 == 5'd0,
				r_fmt || s_fmt};
			exp_const = {e_imm, i_fmt || s_fmt || u_fmt,
				(op == decode_pkg::OP_BEQ) ? pc + e_imm : 32'd0};
			exp_class = {1'b1, cls, cls[4] || cls[3], cls[1] && (&w[31:24])};
			if (m == decode_pkg::MODE_USER && (e_rd >= decode_pkg::PRIV_REG_BASE ||
					e_rs1 >= decode_pkg::PRIV_REG_BASE || e_rs2 >= decode_pkg::PRIV_REG_BASE))
				exp_cause = decode_pkg::FLT_BADREG;
			else
				exp_cause = decode_pkg::FLT_NONE;
		end
	endtask

	// ======================================================================
	// Checks and test sequencing
	// ======================================================================
	task automatic check_group(input string what, input logic [64:0] expv,
			input logic [64:0] actv);
		checks++;
		assert (actv === expv) else begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expv, actv);
			test_errors++;
		end
	endtask

	task automatic check_outputs();
		check_group("regs", 65'(exp_regs), 65'({rd, rs1, rs2, rdz, rs1z, rs2z, has_rs2}));
		check_group("const", exp_const, {imm, has_imm, br_target});
		check_group("class", 65'(exp_class), 65'({dec_valid, is_alu, is_mul, is_div,
			is_load, is_store, is_branch, is_fence, is_nop, mem, sync}));
		check_group("cause", 65'(exp_cause), 65'(cause));
	endtask

	// Kinds: 0 regs, 1 const, 2 class, 3 faults, 4 enable, 5 en held low
	task automatic drive_vector(input int kind, input int idx);
		decode_pkg::instr_t w;
		decode_pkg::opcode_t op;
		w = rand_bits(32);
		op = known_ops[int'(rand_bits(4)) % 10];
		if (kind == 3) begin
			// Unknown opcodes and registers pushed into the privileged range
			if (rand_bits(2) == 0)
				op = 7'(rand_bits(7));
			if (rand_bits(1) != 0)
				w[11:7] = w[11:7] | 5'b11100;
			if (rand_bits(1) != 0)
				w[16:12] = w[16:12] | 5'b11100;
			if (rand_bits(1) != 0)
				w[21:17] = w[21:17] | 5'b11100;
		end
		// Half the fences in the class test ask for a full sync
		if (kind == 2 && rand_bits(1) != 0)
			w[31:24] = 8'hFF;
		w[6:0] = op;
		// Every odd fault vector replays the last word in machine mode
		if (kind == 3 && idx[0])
			om = decode_pkg::MODE_MACHINE;
		else begin
			instr = w;
			ip = rand_bits(32);
			om = (kind == 3) ? decode_pkg::MODE_USER : decode_pkg::mode_t'(rand_bits(2));
		end
		en = kind != 5;
		instr_valid = 1'b1;
		if (kind == 4) begin
			en = rand_bits(2) != 0;
			instr_valid = rand_bits(2) != 0;
		end
		if (en)
			set_expected(instr, ip, om, instr_valid);
	endtask

	task automatic run_test(input string name, input int kind);
		test_name = name;
		test_errors = 0;
		for (int i = 0; i < VECS; i++) begin
			@(negedge clk);
			check_outputs();
			drive_vector(kind, i);
		end
		@(negedge clk);
		check_outputs();
		$display("%-7s %0d vectors, %0d errors", name, VECS, test_errors);
		errors += test_errors;
	endtask

	initial begin
		lfsr = 17'd69223;
		errors = 0;
		checks = 0;
		known_ops = '{decode_pkg::OP_NOP, decode_pkg::OP_ADD, decode_pkg::OP_ADDI,
			decode_pkg::OP_LUI, decode_pkg::OP_MUL, decode_pkg::OP_DIV, decode_pkg::OP_LOAD,
			decode_pkg::OP_STORE, decode_pkg::OP_BEQ, decode_pkg::OP_FENCE};
		rst = 1'b1;
		en = 1'b0;
		instr_valid = 1'b0;
		ip = '0;
		om = decode_pkg::MODE_USER;
		instr = '0;
		set_expected('0, '0, decode_pkg::MODE_USER, 1'b0);
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// The reset test keeps en low, so the reset image has to hold throughout
		run_test("reset", 5);
		run_test("regs", 0);
		run_test("const", 1);
		run_test("class", 2);
		run_test("faults", 3);
		run_test("enable", 4);
		$display("Tests: %0d, checks: %0d, errors: %0d", N_TESTS, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
rtl/decode_pkg.sv
rtl/decode_regs.sv
rtl/decode_const.sv
rtl/decode_class.sv
rtl/decoder.sv
bench/tb_decoder.sv

// File: rtl/decode_class.sv
// Instruction class decoder.
// Turns the opcode into one class flag, which later stages use to steer
// the instruction to a functional unit. An opcode outside the table
// raises unimp and leaves every class flag low.
// Purely combinational.

`timescale 1ns/100ps
`default_nettype none

module decode_class (
	input  wire decode_pkg::instr_t instr,
	output logic                    is_alu,
	output logic                    is_mul,
	output logic                    is_div,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    is_branch,
	output logic                    is_fence,
	output logic                    is_nop,
	output logic                    unimp
);

	decode_pkg::opcode_t op;

	assign op = instr[decode_pkg::FLD_OP_HI:decode_pkg::FLD_OP_LO];

	// ======================================================================
	// Opcode to class
	// ======================================================================
	always_comb begin
		is_alu    = 1'b0;
		is_mul    = 1'b0;
		is_div    = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_fence  = 1'b0;
		is_nop    = 1'b0;
		unimp     = 1'b0;

		case (op)
		decode_pkg::OP_NOP:
			is_nop = 1'b1;
		// The simple integer unit handles the add forms and the upper immediate
		decode_pkg::OP_ADD, decode_pkg::OP_ADDI, decode_pkg::OP_LUI:
			is_alu = 1'b1;
		decode_pkg::OP_MUL:
			is_mul = 1'b1;
		// Division is multi-cycle and gets its own unit
		decode_pkg::OP_DIV:
			is_div = 1'b1;
		decode_pkg::OP_LOAD:
			is_load = 1'b1;
		decode_pkg::OP_STORE:
			is_store = 1'b1;
		decode_pkg::OP_BEQ:
			is_branch = 1'b1;
		decode_pkg::OP_FENCE:
			is_fence = 1'b1;
		default:
			unimp = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/decode_const.sv
// Constant decoder.
// Builds the immediate for the I, S and U formats and the branch target
// of a conditional branch, relative to the instruction address.
// PC_W is the address width and is passed down from the top level.
// Purely combinational.

`timescale 1ns/100ps
`default_nettype none

module decode_const #(
	parameter int PC_W = 32
) (
	input  wire decode_pkg::instr_t instr,
	input  wire [PC_W-1:0]          ip,
	output decode_pkg::value_t      imm,
	output logic                    has_imm,
	output logic [PC_W-1:0]         br_target
);

	localparam int IMM15_W = decode_pkg::FLD_IMM15_HI - decode_pkg::FLD_IMM15_LO + 1;
	localparam int VAL_W   = $bits(decode_pkg::value_t);

	decode_pkg::opcode_t op;
	decode_pkg::fmt_t    fmt;
	decode_pkg::value_t  imm_s;
	decode_pkg::value_t  imm_u;
	logic [PC_W-1:0]     imm_pc;

	assign op  = instr[decode_pkg::FLD_OP_HI:decode_pkg::FLD_OP_LO];
	assign fmt = decode_pkg::op_format(op);

	// I and S formats share the 15-bit field at the top, sign-extended
	assign imm_s = {{(VAL_W - IMM15_W){instr[decode_pkg::FLD_IMM15_HI]}},
		instr[decode_pkg::FLD_IMM15_HI:decode_pkg::FLD_IMM15_LO]};

	// The U constant lands in the upper bits, low 12 bits clear
	assign imm_u = decode_pkg::value_t'(instr[decode_pkg::FLD_IMM20_HI:decode_pkg::FLD_IMM20_LO])
		<< decode_pkg::FLD_IMM20_LO;

	always_comb begin
		case (fmt)
		decode_pkg::FMT_I, decode_pkg::FMT_S: begin
			imm     = imm_s;
			has_imm = 1'b1;
		end
		decode_pkg::FMT_U: begin
			imm     = imm_u;
			has_imm = 1'b1;
		end
		default: begin
			imm     = '0;
			has_imm = 1'b0;
		end
		endcase
	end

	// Displacement fitted to the address width, sign kept if the address is wider
	assign imm_pc = PC_W'($signed(imm));

	// Only the conditional branch carries a target, the sum wraps at PC_W bits
	assign br_target = (op == decode_pkg::OP_BEQ) ? ip + imm_pc : '0;

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
// Shared definitions for the instruction decode stage.
// Holds the instruction field layout, the opcode, mode, fault-cause and
// format codes, and the vector types that give the decode bus its widths.
// Every design and bench file refers to these by scoped names.

`default_nettype none

package decode_pkg;

	// ======================================================================
	// Types
	// ======================================================================
	typedef logic [31:0] instr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [4:0]  reg_t;
	typedef logic [31:0] value_t;
	typedef logic [1:0]  mode_t;
	typedef logic [1:0]  cause_t;
	// Operand format of an opcode, used by the register and constant decoders
	typedef logic [2:0]  fmt_t;

	// Operating modes
	localparam mode_t MODE_USER    = 2'd0;
	localparam mode_t MODE_MACHINE = 2'd3;

	// Fault causes, in rising priority order when more than one applies
	localparam cause_t FLT_NONE   = 2'd0;
	localparam cause_t FLT_BADREG = 2'd1;
	localparam cause_t FLT_UNIMP  = 2'd2;

	// ======================================================================
	// Opcodes and field positions
	// ======================================================================
	localparam opcode_t OP_NOP   = 7'h00;
	localparam opcode_t OP_ADD   = 7'h01;
	localparam opcode_t OP_ADDI  = 7'h02;
	localparam opcode_t OP_LUI   = 7'h03;
	localparam opcode_t OP_MUL   = 7'h04;
	localparam opcode_t OP_DIV   = 7'h05;
	localparam opcode_t OP_LOAD  = 7'h10;
	localparam opcode_t OP_STORE = 7'h11;
	localparam opcode_t OP_BEQ   = 7'h20;
	localparam opcode_t OP_FENCE = 7'h30;

	localparam int FLD_OP_HI    = 6;
	localparam int FLD_OP_LO    = 0;
	localparam int FLD_RD_HI    = 11;
	localparam int FLD_RD_LO    = 7;
	localparam int FLD_RS1_HI   = 16;
	localparam int FLD_RS1_LO   = 12;
	localparam int FLD_RS2_HI   = 21;
	localparam int FLD_RS2_LO   = 17;
	localparam int FLD_IMM15_HI = 31;
	localparam int FLD_IMM15_LO = 17;
	localparam int FLD_IMM20_HI = 31;
	localparam int FLD_IMM20_LO = 12;
	localparam int FLD_SYNC_HI  = 31;
	localparam int FLD_SYNC_LO  = 24;

	// In user mode the registers from here up are reserved for the kernel
	localparam reg_t PRIV_REG_BASE = 5'd28;

	// Operand formats
	localparam fmt_t FMT_NONE = 3'd0;
	localparam fmt_t FMT_R    = 3'd1;
	localparam fmt_t FMT_I    = 3'd2;
	localparam fmt_t FMT_S    = 3'd3;
	localparam fmt_t FMT_U    = 3'd4;

	// Format of each opcode. NOP, FENCE and any unknown opcode use no operands
	function automatic fmt_t op_format(input opcode_t op);
		case (op)
		OP_ADD, OP_MUL, OP_DIV: return FMT_R;
		OP_ADDI, OP_LOAD:       return FMT_I;
		OP_STORE, OP_BEQ:       return FMT_S;
		OP_LUI:                 return FMT_U;
		default:                return FMT_NONE;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: rtl/decode_regs.sv
// Register specifier decoder.
// Picks the destination and the two source specifiers out of the
// instruction word according to the opcode's format, flags the ones that
// read as register zero, and reports a privileged register in user mode.
// Purely combinational; the top level registers the results.

`timescale 1ns/100ps
`default_nettype none

module decode_regs (
	input  wire decode_pkg::instr_t instr,
	input  wire decode_pkg::mode_t  om,
	output decode_pkg::reg_t        rd,
	output decode_pkg::reg_t        rs1,
	output decode_pkg::reg_t        rs2,
	output logic                    rdz,
	output logic                    rs1z,
	output logic                    rs2z,
	output logic                    has_rs2,
	output logic                    priv_fault
);

	decode_pkg::fmt_t fmt;
	decode_pkg::reg_t fld_rd;
	decode_pkg::reg_t fld_rs1;
	decode_pkg::reg_t fld_rs2;
	logic             use_rd;
	logic             use_rs1;
	logic             is_user;

	assign fmt = decode_pkg::op_format(instr[decode_pkg::FLD_OP_HI:decode_pkg::FLD_OP_LO]);

	// Raw fields, before the format decides which of them mean anything
	assign fld_rd  = instr[decode_pkg::FLD_RD_HI:decode_pkg::FLD_RD_LO];
	assign fld_rs1 = instr[decode_pkg::FLD_RS1_HI:decode_pkg::FLD_RS1_LO];
	assign fld_rs2 = instr[decode_pkg::FLD_RS2_HI:decode_pkg::FLD_RS2_LO];

	// Stores and branches have no destination
	assign use_rd  = fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_I ||
		fmt == decode_pkg::FMT_U;
	assign use_rs1 = fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_I ||
		fmt == decode_pkg::FMT_S;
	assign has_rs2 = fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_S;

	assign rd  = use_rd ? fld_rd : '0;
	assign rs1 = use_rs1 ? fld_rs1 : '0;

	// S-format reuses the destination field for its second source, which
	// keeps the immediate field contiguous at the top of the word
	always_comb begin
		case (fmt)
		decode_pkg::FMT_R: rs2 = fld_rs2;
		decode_pkg::FMT_S: rs2 = fld_rd;
		default:           rs2 = '0;
		endcase
	end

	// An unused specifier reads as 0, so it also reports as zero
	assign rdz  = rd == '0;
	assign rs1z = rs1 == '0;
	assign rs2z = rs2 == '0;

	// Unused specifiers are 0 and never reach the privileged range
	assign is_user    = om == decode_pkg::MODE_USER;
	assign priv_fault = is_user && (rd >= decode_pkg::PRIV_REG_BASE ||
		rs1 >= decode_pkg::PRIV_REG_BASE || rs2 >= decode_pkg::PRIV_REG_BASE);

endmodule

`default_nettype wire

// File: rtl/decoder.sv
// Instruction decode stage, top level.
// Feeds the fetched word to the register, constant and class decoders and
// registers their results as the decode bus on every enabled clock edge.
// On the way it adds the memory and fence flags and the fault cause.
// The pipeline stalls this stage by lowering en, which holds the outputs.

`timescale 1ns/100ps
`default_nettype none

module decoder #(
	parameter int PC_W = 32
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     en,
	input  wire [PC_W-1:0]          ip,
	input  wire decode_pkg::mode_t  om,
	input  wire decode_pkg::instr_t instr,
	input  wire                     instr_valid,
	output logic                    dec_valid,
	output decode_pkg::reg_t        rd,
	output decode_pkg::reg_t        rs1,
	output decode_pkg::reg_t        rs2,
	output logic                    rdz,
	output logic                    rs1z,
	output logic                    rs2z,
	output logic                    has_rs2,
	output decode_pkg::value_t      imm,
	output logic                    has_imm,
	output logic [PC_W-1:0]         br_target,
	output logic                    is_alu,
	output logic                    is_mul,
	output logic                    is_div,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    is_branch,
	output logic                    is_fence,
	output logic                    is_nop,
	output logic                    mem,
	output logic                    sync,
	output decode_pkg::cause_t      cause
);

	// Combinational decode of the current word
	decode_pkg::reg_t   d_rd, d_rs1, d_rs2;
	logic               d_rdz, d_rs1z, d_rs2z, d_has_rs2, priv_fault;
	decode_pkg::value_t d_imm;
	logic               d_has_imm;
	logic [PC_W-1:0]    d_br_target;
	logic               d_alu, d_mul, d_div, d_load, d_store, d_branch, d_fence, d_nop;
	logic               unimp;
	logic               sync_all;
	logic               slot_clear;
	logic               slot_unimp;

	decode_regs u_regs (
		.instr(instr), .om(om),
		.rd(d_rd), .rs1(d_rs1), .rs2(d_rs2),
		.rdz(d_rdz), .rs1z(d_rs1z), .rs2z(d_rs2z),
		.has_rs2(d_has_rs2), .priv_fault(priv_fault)
	);

	decode_const #(.PC_W(PC_W)) u_const (
		.instr(instr), .ip(ip),
		.imm(d_imm), .has_imm(d_has_imm), .br_target(d_br_target)
	);

	decode_class u_class (
		.instr(instr),
		.is_alu(d_alu), .is_mul(d_mul), .is_div(d_div), .is_load(d_load),
		.is_store(d_store), .is_branch(d_branch), .is_fence(d_fence), .is_nop(d_nop),
		.unimp(unimp)
	);

	// A full fence only when every sync bit is set
	assign sync_all = &instr[decode_pkg::FLD_SYNC_HI:decode_pkg::FLD_SYNC_LO];

	// Empty slot, or an opcode we cannot decode. Both load the reset image
	assign slot_clear = en && !instr_valid;
	assign slot_unimp = en && instr_valid && unimp;

	// ======================================================================
	// Decode bus register
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst || slot_clear || slot_unimp) begin
			dec_valid <= 1'b0;
			{rd, rs1, rs2} <= '0;
			rdz       <= 1'b1;
			{rs1z, rs2z, has_rs2} <= '0;
			imm       <= '0;
			has_imm   <= 1'b0;
			br_target <= '0;
			{is_alu, is_mul, is_div, is_load, is_store, is_branch, is_fence} <= '0;
			is_nop    <= 1'b1;
			{mem, sync} <= '0;
			cause     <= decode_pkg::FLT_NONE;
			// An unknown opcode is still a real slot and carries its fault onward
			if (!rst && slot_unimp) begin
				dec_valid <= 1'b1;
				is_nop    <= 1'b0;
				cause     <= decode_pkg::FLT_UNIMP;
			end
		end
		else if (en) begin
			dec_valid <= 1'b1;
			{rd, rs1, rs2} <= {d_rd, d_rs1, d_rs2};
			{rdz, rs1z, rs2z, has_rs2} <= {d_rdz, d_rs1z, d_rs2z, d_has_rs2};
			imm       <= d_imm;
			has_imm   <= d_has_imm;
			br_target <= d_br_target;
			{is_alu, is_mul, is_div, is_load} <= {d_alu, d_mul, d_div, d_load};
			{is_store, is_branch, is_fence, is_nop} <= {d_store, d_branch, d_fence, d_nop};
			mem       <= d_load || d_store;
			sync      <= d_fence && sync_all;
			// Unknown opcodes were handled above, so only the register check is left
			cause     <= priv_fault ? decode_pkg::FLT_BADREG : decode_pkg::FLT_NONE;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the decode stage with its testbench in Verilator and runs it.
# The run passes only if the testbench prints its pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decoder -f filelist.f

out=$(./obj_dir/Vtb_decoder)
echo "$out"
echo "$out" | grep -qx "No errors"
